// File: source/motor_cfg_pkg.sv
package motor_cfg_pkg;

	// half-period count in prescaled ticks
	localparam int SPEED_W = 16;

	// steps per move
	localparam int STEP_W = 16;

	// microstep code for the driver
	localparam int MS_W = 3;

	// speed profile tables
	localparam int TAB_AW = 8;
	localparam int TAB_DEPTH = 256;

	// tick divisor
	localparam int PRESC_W = 16;

	typedef logic [SPEED_W-1:0] speed_t;
	typedef logic [STEP_W-1:0]  step_t;
	typedef logic [MS_W-1:0]    ms_t;
	typedef logic [TAB_AW-1:0]  tab_addr_t;
	typedef logic [PRESC_W-1:0] presc_t;

endpackage

// File: source/motor_bus_pkg.sv
package motor_bus_pkg;

	localparam int APB_AW = 12;
	localparam int APB_DW = 32;

	// register map in byte offsets
	localparam logic [APB_AW-1:0] REG_CTRL     = 12'h000;
	localparam logic [APB_AW-1:0] REG_SPEED    = 12'h004;
	localparam logic [APB_AW-1:0] REG_STEPS    = 12'h008;
	localparam logic [APB_AW-1:0] REG_PRESC    = 12'h00C;
	localparam logic [APB_AW-1:0] REG_ACCE_MAX = 12'h010;
	localparam logic [APB_AW-1:0] REG_DEAC_MAX = 12'h014;
	localparam logic [APB_AW-1:0] REG_STATUS   = 12'h018;

	// table regions with one word per entry
	localparam logic [APB_AW-1:0] ACCE_BASE    = 12'h400;
	localparam logic [APB_AW-1:0] DEAC_BASE    = 12'h800;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [APB_AW-1:0] paddr;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// start and stop are single-cycle pulses
	typedef struct packed {
		logic                     start;
		logic                     stop;
		logic                     dir;
		motor_cfg_pkg::ms_t       ms;
		motor_cfg_pkg::speed_t    speed;
		motor_cfg_pkg::step_t     steps;
		motor_cfg_pkg::presc_t    presc;
		motor_cfg_pkg::tab_addr_t acce_max;
		motor_cfg_pkg::tab_addr_t deac_max;
	} motor_cmd_t;

	typedef struct packed {
		logic                     en;
		motor_cfg_pkg::tab_addr_t addr;
		motor_cfg_pkg::speed_t    data;
	} tab_wr_t;

	typedef struct packed {
		logic                 busy;
		motor_cfg_pkg::step_t steps;
	} motor_stat_t;

endpackage

// File: source/motor_apb_regs.sv
module motor_apb_regs (
	input  logic                       clk,
	input  logic                       resetn,
	input  motor_bus_pkg::apb_req_t    i_apb,
	output motor_bus_pkg::apb_rsp_t    o_apb,
	output motor_bus_pkg::motor_cmd_t  o_cmd,
	output motor_bus_pkg::tab_wr_t     o_acce_wr,
	output motor_bus_pkg::tab_wr_t     o_deac_wr,
	input  motor_bus_pkg::motor_stat_t i_stat
);
	import motor_cfg_pkg::*;
	import motor_bus_pkg::*;

	motor_cmd_t        cmd;
	logic              wr_commit;
	logic              acce_hit;
	logic              deac_hit;
	logic              reg_hit;
	logic [APB_DW-1:0] rdata;
	logic              acce_en;
	logic              deac_en;
	tab_addr_t         tab_addr;
	speed_t            tab_data;

	assign wr_commit = i_apb.psel && i_apb.penable && i_apb.pwrite;

	assign acce_hit = (i_apb.paddr >= ACCE_BASE) && (i_apb.paddr < ACCE_BASE + TAB_DEPTH * 4);
	assign deac_hit = (i_apb.paddr >= DEAC_BASE) && (i_apb.paddr < DEAC_BASE + TAB_DEPTH * 4);

	// read mux; table regions fall through as zero
	always_comb begin
		reg_hit = 1'b1;
		rdata = '0;
		case (i_apb.paddr)
			REG_CTRL: begin
				rdata[2] = cmd.dir;
				rdata[4 +: MS_W] = cmd.ms;
			end
			REG_SPEED:    rdata[SPEED_W-1:0] = cmd.speed;
			REG_STEPS:    rdata[STEP_W-1:0] = cmd.steps;
			REG_PRESC:    rdata[PRESC_W-1:0] = cmd.presc;
			REG_ACCE_MAX: rdata[TAB_AW-1:0] = cmd.acce_max;
			REG_DEAC_MAX: rdata[TAB_AW-1:0] = cmd.deac_max;
			REG_STATUS: begin
				rdata[0] = i_stat.busy;
				rdata[16 +: STEP_W] = i_stat.steps;
			end
			default: reg_hit = 1'b0;
		endcase
	end

	assign o_apb.prdata = rdata;
	assign o_apb.pready = 1'b1;
	assign o_apb.pslverr = i_apb.psel && i_apb.penable && !(reg_hit || acce_hit || deac_hit);

	// config registers with pulsed start and stop
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cmd <= '0;
		end else begin
			cmd.start <= 1'b0;
			cmd.stop <= 1'b0;
			if (wr_commit) begin
				case (i_apb.paddr)
					REG_CTRL: begin
						cmd.start <= i_apb.pwdata[0];
						cmd.stop <= i_apb.pwdata[1];
						cmd.dir <= i_apb.pwdata[2];
						cmd.ms <= i_apb.pwdata[4 +: MS_W];
					end
					REG_SPEED:    cmd.speed <= i_apb.pwdata[SPEED_W-1:0];
					REG_STEPS:    cmd.steps <= i_apb.pwdata[STEP_W-1:0];
					REG_PRESC:    cmd.presc <= i_apb.pwdata[PRESC_W-1:0];
					REG_ACCE_MAX: cmd.acce_max <= i_apb.pwdata[TAB_AW-1:0];
					REG_DEAC_MAX: cmd.deac_max <= i_apb.pwdata[TAB_AW-1:0];
					default: ;
				endcase
			end
		end
	end

	assign o_cmd = cmd;

	// table write steering
	always_ff @(posedge clk) begin
		if (!resetn) begin
			acce_en <= 1'b0;
			deac_en <= 1'b0;
		end else begin
			acce_en <= wr_commit && acce_hit;
			deac_en <= wr_commit && deac_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_commit) begin
			tab_addr <= i_apb.paddr[2 +: TAB_AW];
			tab_data <= i_apb.pwdata[SPEED_W-1:0];
		end
	end

	assign o_acce_wr = '{en: acce_en, addr: tab_addr, data: tab_data};
	assign o_deac_wr = '{en: deac_en, addr: tab_addr, data: tab_data};

endmodule

// File: source/speed_profile_ram.sv
module speed_profile_ram #(
	parameter int DEPTH = motor_cfg_pkg::TAB_DEPTH
) (
	input  logic                     clk,
	input  motor_bus_pkg::tab_wr_t   i_wr,
	input  logic                     i_rd_en,
	input  motor_cfg_pkg::tab_addr_t i_rd_addr,
	output motor_cfg_pkg::speed_t    o_rd_data
);
	import motor_cfg_pkg::*;

	// one half-period per step index
	speed_t mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (i_wr.en)
			mem[i_wr.addr] <= i_wr.data;
	end

	// registered read with data one clock after enable
	always_ff @(posedge clk) begin
		if (i_rd_en)
			o_rd_data <= mem[i_rd_addr];
	end

endmodule

// File: source/step_pulse_gen.sv
module step_pulse_gen (
	input  logic                       clk,
	input  logic                       resetn,
	input  motor_bus_pkg::motor_cmd_t  i_cmd,
	output logic                       o_acce_rd_en,
	output motor_cfg_pkg::tab_addr_t   o_acce_addr,
	input  motor_cfg_pkg::speed_t      i_acce_data,
	output logic                       o_deac_rd_en,
	output motor_cfg_pkg::tab_addr_t   o_deac_addr,
	input  motor_cfg_pkg::speed_t      i_deac_data,
	output logic                       o_drive,
	output logic                       o_dir,
	output motor_cfg_pkg::ms_t         o_ms,
	output motor_bus_pkg::motor_stat_t o_stat
);
	import motor_cfg_pkg::*;

	typedef enum logic {
		IDLE,
		RUNNING
	} state_t;

	state_t state;
	presc_t presc_cnt;
	logic   tick;
	logic   start_pend;
	logic   stop_pend;
	speed_t speed_max;
	speed_t speed_cur;
	speed_t speed_cnt;
	speed_t speed_var;
	step_t  step_cnt;
	step_t  step_remain;
	step_t  step_issued;
	logic   step_done;
	logic   cnt_zero;
	logic   go;
	logic   halt;
	logic   edge_en;
	logic   rise;
	logic   fall;
	logic   rd_en;
	logic   rd_en_d1;
	logic   rd_en_d2;

	// tick every presc+1 clocks
	always_ff @(posedge clk) begin
		if (!resetn)
			presc_cnt <= '0;
		else if (tick)
			presc_cnt <= '0;
		else
			presc_cnt <= presc_cnt + 1'b1;
	end

	assign tick = (presc_cnt >= i_cmd.presc);

	// start/stop wait here for the next tick
	always_ff @(posedge clk) begin
		if (!resetn) begin
			start_pend <= 1'b0;
			stop_pend <= 1'b0;
		end else begin
			if (start_pend) begin
				if (tick)
					start_pend <= 1'b0;
			end else if (i_cmd.start && state == IDLE) begin
				start_pend <= 1'b1;
			end
			if (stop_pend) begin
				if (tick)
					stop_pend <= 1'b0;
			end else if (i_cmd.stop && state == RUNNING) begin
				stop_pend <= 1'b1;
			end
		end
	end

	assign cnt_zero = (speed_cnt == '0);
	assign go = tick && state == IDLE && start_pend && (i_cmd.steps != '0);
	assign halt = tick && state == RUNNING && (stop_pend || (step_done && cnt_zero));
	assign edge_en = tick && state == RUNNING && cnt_zero && !step_done && !stop_pend;
	assign rise = edge_en && !o_drive;
	assign fall = edge_en && o_drive;

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= IDLE;
		else if (go)
			state <= RUNNING;
		else if (halt)
			state <= IDLE;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_dir <= 1'b0;
			o_ms <= '0;
		end else if (go) begin
			o_dir <= i_cmd.dir;
			o_ms <= i_cmd.ms;
		end
	end

	// last step seen with drive high
	always_ff @(posedge clk) begin
		if (!resetn)
			step_done <= 1'b0;
		else if (tick) begin
			if (state == IDLE)
				step_done <= 1'b0;
			else if (o_drive && step_remain == '0)
				step_done <= 1'b1;
		end
	end

	// table index and steps left
	always_ff @(posedge clk) begin
		if (!resetn) begin
			step_cnt <= '0;
			step_remain <= '0;
		end else if (go) begin
			step_cnt <= '0;
			step_remain <= i_cmd.steps - 1'b1;
		end else if (fall) begin
			step_cnt <= step_cnt + 1'b1;
			step_remain <= step_remain - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			step_issued <= '0;
		else if (go)
			step_issued <= '0;
		else if (rise)
			step_issued <= step_issued + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			speed_cnt <= '0;
		else if (tick) begin
			if (state == IDLE)
				speed_cnt <= '0;
			else if (cnt_zero)
				speed_cnt <= speed_cur;
			else
				speed_cnt <= speed_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			o_drive <= 1'b0;
		else if (halt)
			o_drive <= 1'b0;
		else if (edge_en)
			o_drive <= !o_drive;
	end

	// profile lookup at start and after each completed step
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_en <= 1'b0;
			rd_en_d1 <= 1'b0;
			rd_en_d2 <= 1'b0;
		end else begin
			rd_en <= go || fall;
			rd_en_d1 <= rd_en;
			rd_en_d2 <= rd_en_d1;
		end
	end

	assign o_acce_rd_en = rd_en;
	assign o_deac_rd_en = rd_en;
	assign o_acce_addr = (step_cnt > step_t'(i_cmd.acce_max)) ? i_cmd.acce_max
		: tab_addr_t'(step_cnt);
	assign o_deac_addr = (step_remain > step_t'(i_cmd.deac_max)) ? i_cmd.deac_max
		: tab_addr_t'(step_remain);

	// slowest of acce, deac and cruise
	always_ff @(posedge clk) begin
		if (rd_en_d1)
			speed_var <= (i_acce_data > i_deac_data) ? i_acce_data : i_deac_data;
	end

	always_ff @(posedge clk) begin
		if (go) begin
			speed_max <= i_cmd.speed;
			speed_cur <= i_cmd.speed;
		end else if (rd_en_d2) begin
			speed_cur <= (speed_var > speed_max) ? speed_var : speed_max;
		end
	end

	assign o_stat.busy = (state == RUNNING);
	assign o_stat.steps = step_issued;

endmodule

// File: source/motor_ctrl_top.sv
module motor_ctrl_top (
	input  logic                    clk,
	input  logic                    resetn,
	input  motor_bus_pkg::apb_req_t i_apb,
	output motor_bus_pkg::apb_rsp_t o_apb,
	output logic                    o_drive,
	output logic                    o_dir,
	output motor_cfg_pkg::ms_t      o_ms
);
	import motor_cfg_pkg::*;
	import motor_bus_pkg::*;

	motor_cmd_t  cmd;
	motor_stat_t stat;
	tab_wr_t     acce_wr;
	tab_wr_t     deac_wr;
	logic        acce_rd_en;
	logic        deac_rd_en;
	tab_addr_t   acce_addr;
	tab_addr_t   deac_addr;
	speed_t      acce_data;
	speed_t      deac_data;

	motor_apb_regs regs (
		.clk       (clk),
		.resetn    (resetn),
		.i_apb     (i_apb),
		.o_apb     (o_apb),
		.o_cmd     (cmd),
		.o_acce_wr (acce_wr),
		.o_deac_wr (deac_wr),
		.i_stat    (stat)
	);

	// acceleration profile
	speed_profile_ram #(
		.DEPTH (TAB_DEPTH)
	) acce_tab (
		.clk       (clk),
		.i_wr      (acce_wr),
		.i_rd_en   (acce_rd_en),
		.i_rd_addr (acce_addr),
		.o_rd_data (acce_data)
	);

	// deceleration profile
	speed_profile_ram #(
		.DEPTH (TAB_DEPTH)
	) deac_tab (
		.clk       (clk),
		.i_wr      (deac_wr),
		.i_rd_en   (deac_rd_en),
		.i_rd_addr (deac_addr),
		.o_rd_data (deac_data)
	);

	step_pulse_gen gen (
		.clk          (clk),
		.resetn       (resetn),
		.i_cmd        (cmd),
		.o_acce_rd_en (acce_rd_en),
		.o_acce_addr  (acce_addr),
		.i_acce_data  (acce_data),
		.o_deac_rd_en (deac_rd_en),
		.o_deac_addr  (deac_addr),
		.i_deac_data  (deac_data),
		.o_drive      (o_drive),
		.o_dir        (o_dir),
		.o_ms         (o_ms),
		.o_stat       (stat)
	);

endmodule

// File: sim/motor_ctrl_asserts.sv
module motor_ctrl_asserts (
	input logic                    clk,
	input logic                    resetn,
	input motor_bus_pkg::apb_req_t i_apb,
	input motor_bus_pkg::apb_rsp_t o_apb,
	input logic                    o_drive,
	input logic                    o_dir,
	input motor_cfg_pkg::ms_t      o_ms,
	input logic                    i_busy
);

	// no wait states on the bus
	pready_in_access: assert property (@(posedge clk) disable iff (!resetn)
		i_apb.psel && i_apb.penable |-> o_apb.pready)
	else $error("pready low during an APB access phase");

	// halt drops drive together with busy so only idle-to-idle counts
	drive_quiet_idle: assert property (@(posedge clk) disable iff (!resetn)
		!i_busy && !$past(i_busy) |-> $stable(o_drive))
	else $error("o_drive toggled while the generator is idle");

	dir_ms_held: assert property (@(posedge clk) disable iff (!resetn)
		i_busy && $past(i_busy) |-> $stable(o_dir) && $stable(o_ms))
	else $error("o_dir or o_ms changed during a move");

endmodule

bind motor_ctrl_top motor_ctrl_asserts chk (
	.clk     (clk),
	.resetn  (resetn),
	.i_apb   (i_apb),
	.o_apb   (o_apb),
	.o_drive (o_drive),
	.o_dir   (o_dir),
	.o_ms    (o_ms),
	.i_busy  (stat.busy)
);

// File: sim/motor_ctrl_tb.sv
module motor_ctrl_tb;
	import motor_cfg_pkg::*;
	import motor_bus_pkg::*;

	localparam int TIMEOUT = 20000;

	logic     clk;
	logic     resetn;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     drive;
	logic     dir;
	ms_t      ms;

	int       fd;
	int       tests = 0;
	int       failed = 0;
	int       errors = 0;
	int       test_err = 0;
	int       cycle = 0;
	int       edge_cnt = 0;
	logic     drive_q = 1'b0;
	int       rise_at[$];
	int       acce_tab[$];
	int       deac_tab[$];

	motor_ctrl_top uut (
		.clk     (clk),
		.resetn  (resetn),
		.i_apb   (apb_req),
		.o_apb   (apb_rsp),
		.o_drive (drive),
		.o_dir   (dir),
		.o_ms    (ms)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// step output monitor records the cycle of every rising edge
	always @(posedge clk) begin
		cycle <= cycle + 1;
		drive_q <= drive;
		if (drive && !drive_q) begin
			edge_cnt <= edge_cnt + 1;
			rise_at.push_back(cycle);
		end
	end

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			test_err++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("wait for %s timed out after %0d cycles", what, TIMEOUT);
		test_err++;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d (%s) %s", tests, name, (test_err == 0) ? "ok" : "FAILED");
		if (test_err != 0)
			failed++;
		errors += test_err;
		test_err = 0;
	endtask

	task automatic bus_transfer(input logic write, input logic [APB_AW-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		apb_req_t r;
		int n;
		r = '0;
		r.psel = 1'b1;
		r.pwrite = write;
		r.paddr = addr;
		r.pwdata = wdata;
		@(posedge clk);
		apb_req <= r;
		r.penable = 1'b1;
		@(posedge clk);
		apb_req <= r;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!apb_rsp.pready && n < TIMEOUT);
		if (!apb_rsp.pready)
			report_timeout("pready");
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		apb_req <= '0;
	endtask

	task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		bus_transfer(1'b1, addr, data, rd, err);
		check_equal($sformatf("pslverr on write to %03h", addr), err, 0);
	endtask

	task automatic read_reg(input logic [APB_AW-1:0] addr, output logic [31:0] data,
			output logic err);
		bus_transfer(1'b0, addr, '0, data, err);
	endtask

	// whitespace separated tokens with # comments to end of line
	task automatic next_token(output string t, output bit ok);
		string rest;
		int r;
		ok = 1'b0;
		forever begin
			r = $fscanf(fd, "%s", t);
			if (r != 1)
				return;
			if (t[0] != "#")
				break;
			r = $fgets(rest, fd);
		end
		ok = 1'b1;
	endtask

	task automatic read_num(input bit hex, output int v);
		string t;
		bit ok;
		next_token(t, ok);
		if (!ok) begin
			$display("pattern file ends inside a record");
			test_err++;
		end
		v = hex ? t.atohex() : t.atoi();
	endtask

	// slowest of acce entry, deac entry and cruise at clamped addresses
	function automatic int half_period(input int j, input int speed, input int steps);
		int s;
		int a;
		int d;
		a = (j < acce_tab.size()) ? j : acce_tab.size() - 1;
		d = (steps - 1 - j < deac_tab.size()) ? steps - 1 - j : deac_tab.size() - 1;
		s = speed;
		if (acce_tab[a] > s)
			s = acce_tab[a];
		if (deac_tab[d] > s)
			s = deac_tab[d];
		return s;
	endfunction

	task automatic load_table(input bit deac);
		int last;
		int v;
		int i;
		read_num(1'b0, last);
		if (deac)
			deac_tab.delete();
		else
			acce_tab.delete();
		for (i = 0; i <= last; i++) begin
			read_num(1'b0, v);
			write_reg((deac ? DEAC_BASE : ACCE_BASE) + 4 * i, v);
			if (deac)
				deac_tab.push_back(v);
			else
				acce_tab.push_back(v);
		end
	endtask

	task automatic wait_edges(input int target, input string what);
		int n;
		n = 0;
		while (edge_cnt < target && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (edge_cnt < target)
			report_timeout(what);
	endtask

	task automatic run_reg_test();
		int addr;
		int wdata;
		int exp;
		logic [31:0] rd;
		logic err;
		read_num(1'b1, addr);
		read_num(1'b1, wdata);
		read_num(1'b1, exp);
		write_reg(addr, wdata);
		read_reg(addr, rd, err);
		check_equal($sformatf("prdata[%03h]", addr), rd, exp);
		check_equal("pslverr", err, 0);
		end_test($sformatf("register %03h", addr));
	endtask

	task automatic run_unmapped_test();
		int addr;
		logic [31:0] rd;
		logic err;
		read_num(1'b1, addr);
		read_reg(addr, rd, err);
		check_equal("pslverr", err, 1);
		end_test($sformatf("unmapped %03h", addr));
	endtask

	task automatic run_move_test();
		int mdir;
		int mms;
		int speed;
		int steps;
		int presc;
		int stop_at;
		int restart;
		int exp_edges;
		int ctrl;
		int base_edge;
		int base_rise;
		int got;
		int k;
		int n;
		logic [31:0] rd;
		logic err;
		read_num(1'b0, mdir);
		read_num(1'b0, mms);
		read_num(1'b0, speed);
		read_num(1'b0, steps);
		read_num(1'b0, presc);
		read_num(1'b0, stop_at);
		read_num(1'b0, restart);
		read_num(1'b0, exp_edges);
		write_reg(REG_SPEED, speed);
		write_reg(REG_STEPS, steps);
		write_reg(REG_PRESC, presc);
		write_reg(REG_ACCE_MAX, acce_tab.size() - 1);
		write_reg(REG_DEAC_MAX, deac_tab.size() - 1);
		ctrl = (mdir << 2) | (mms << 4);
		base_edge = edge_cnt;
		base_rise = rise_at.size();
		write_reg(REG_CTRL, ctrl | 1);
		wait_edges(base_edge + 1, "first step");
		check_equal("o_dir", dir, mdir);
		check_equal("o_ms", ms, mms);
		// start while running must not restart the move
		if (restart != 0)
			write_reg(REG_CTRL, ctrl | 1);
		if (stop_at != 0) begin
			wait_edges(base_edge + stop_at, "stop point");
			write_reg(REG_CTRL, ctrl | 2);
		end
		n = 0;
		do begin
			read_reg(REG_STATUS, rd, err);
			n++;
		end while (rd[0] && n < TIMEOUT);
		if (rd[0])
			report_timeout("busy to fall");
		got = edge_cnt - base_edge;
		check_equal("rising edges", got, exp_edges);
		check_equal("status.steps", rd[31:16], got);
		for (k = 1; k < got; k++) begin
			check_equal($sformatf("spacing after step %0d", k),
				rise_at[base_rise + k] - rise_at[base_rise + k - 1],
				2 * (half_period(k - 1, speed, steps) + 1) * (presc + 1));
		end
		end_test($sformatf("move of %0d steps", steps));
	endtask

	initial begin
		string kind;
		bit ok;
		logic [31:0] rd;
		logic err;
		apb_req = '0;
		resetn = 1'b0;
		fd = $fopen("sim/motor_patterns.txt", "r");
		repeat (2) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		check_equal("o_drive", drive, 0);
		check_equal("acce_wr.en", uut.acce_wr.en, 0);
		check_equal("deac_wr.en", uut.deac_wr.en, 0);
		read_reg(REG_STATUS, rd, err);
		check_equal("status.busy", rd[0], 0);
		end_test("reset");
		if (fd == 0) begin
			$display("cannot open sim/motor_patterns.txt");
			errors++;
		end else begin
			next_token(kind, ok);
			while (ok) begin
				if (kind == "reg")
					run_reg_test();
				else if (kind == "bad")
					run_unmapped_test();
				else if (kind == "acce")
					load_table(1'b0);
				else if (kind == "deac")
					load_table(1'b1);
				else if (kind == "move")
					run_move_test();
				else begin
					$display("unknown record %s in pattern file", kind);
					errors++;
				end
				next_token(kind, ok);
			end
			$fclose(fd);
		end
		$display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0 && test_err == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: sim/motor_patterns.txt
# reg <offset> <write> <read>, all hex ; bad <offset>, hex, read expects pslverr
# acce|deac <last index> <entries> ; move <dir> <ms> <speed> <steps> <presc> <stop_at> <restart> <edges>
reg 004 0000abcd 0000abcd
reg 008 00010123 00000123   # steps register is 16 bits
reg 00c 00005678 00005678
reg 010 000001ff 000000ff
reg 014 00000042 00000042
reg 000 000000f6 00000074   # stop bit and bit 7 read back as zero
reg 404 00000055 00000000   # table regions are write-only
bad 01c
bad 3fc
bad c00
# presc stays at 4 or more so a lookup lands within one tick
# short tables below the cruise value
acce 3 2 2 2 2
deac 3 2 2 2 2
move 1 5 9 12 4 0 0 12
# ramps slower than cruise at both ends
acce 4 40 30 22 15 10
deac 3 35 25 18 12
move 0 3 9 16 4 0 0 16
# start while busy is ignored
move 1 2 6 10 5 0 1 10
# stop after the third step
move 0 7 20 40 6 3 1 3

// File: list.f
source/motor_cfg_pkg.sv
source/motor_bus_pkg.sv
source/motor_apb_regs.sv
source/speed_profile_ram.sv
source/step_pulse_gen.sv
source/motor_ctrl_top.sv
sim/motor_ctrl_asserts.sv
sim/motor_ctrl_tb.sv

// File: Makefile
RTL = source/motor_cfg_pkg.sv source/motor_bus_pkg.sv source/motor_apb_regs.sv \
	source/speed_profile_ram.sv source/step_pulse_gen.sv source/motor_ctrl_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module motor_ctrl_top $(RTL)

obj_dir/Vmotor_ctrl_tb: list.f $(RTL) sim/motor_ctrl_tb.sv sim/motor_ctrl_asserts.sv
	verilator --binary --timing --assert -Wno-fatal --top-module motor_ctrl_tb -f list.f

sim: obj_dir/Vmotor_ctrl_tb
	./obj_dir/Vmotor_ctrl_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
